/* src/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  // fetch moves one word per cycle
  localparam word_t pc_step = 32'd4;

  // base opcodes of the kept instruction groups
  localparam opcode_t op_lui = 7'b0110111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_environ = 7'b1110011;

  // funct7 that turns add into sub and srl into sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // class of the slot seen in writeback, one hot apart from invalid
  typedef enum logic [2:0] {
    cycle_invalid      = 3'd0,
    cycle_reset        = 3'd1,
    cycle_no_stall     = 3'd2,
    cycle_taken_branch = 3'd4
  } cycle_status_e;

  // decoded operation, anything unknown ends up as op_nop
  typedef enum logic [5:0] {
    op_nop,
    op_load_upper,
    op_addi,
    op_slti,
    op_sltiu,
    op_xori,
    op_ori,
    op_andi,
    op_slli,
    op_srli,
    op_srai,
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu,
    op_ecall
  } op_e;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
  } fetch_slot_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    op_e           op;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    word_t         imm;
    logic [4:0]    shamt;
  } exec_slot_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rd;
    word_t         rd_data;
    logic          we;
    logic          halt;
  } retire_slot_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

endpackage

/* src/fetch_unit.sv */
module fetch_unit (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::redirect_t   redirect,
  output rv_pkg::word_t       imem_addr,
  input  rv_pkg::insn_t       imem_data,
  output rv_pkg::fetch_slot_t fetch_slot
);

  // pc is the address going out now, pc_d the one whose word is coming back
  rv_pkg::word_t pc;
  rv_pkg::word_t pc_d;
  rv_pkg::cycle_status_e status_d;
  logic live;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
      status_d <= rv_pkg::cycle_reset;
    end else if (redirect.taken) begin
      pc <= redirect.target;
      // the word already requested belongs to the wrong path
      status_d <= rv_pkg::cycle_taken_branch;
    end else begin
      pc <= pc + rv_pkg::pc_step;
      status_d <= rv_pkg::cycle_no_stall;
    end
  end

  always_ff @(posedge clk) begin
    pc_d <= pc;
  end

  assign imem_addr = pc;
  assign live = (status_d == rv_pkg::cycle_no_stall);

  // a flushed or reset word goes on as an all-zero bubble
  assign fetch_slot = '{
    pc: live ? pc_d : '0,
    insn: live ? imem_data : '0,
    status: status_d
  };

  // branch targets come from execute, so alignment is checked here
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("fetch address %h is not word aligned", pc);

endmodule

/* src/decode_stage.sv */
module decode_stage (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::redirect_t   redirect,
  input  rv_pkg::fetch_slot_t fetch_slot,
  output rv_pkg::exec_slot_t  exec_slot
);

  rv_pkg::fetch_slot_t dec_q;
  rv_pkg::opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t imm;
  rv_pkg::op_e op;
  logic writes_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_q <= '{pc: '0, insn: '0, status: rv_pkg::cycle_reset};
    end else if (redirect.taken) begin
      dec_q <= '{pc: '0, insn: '0, status: rv_pkg::cycle_taken_branch};
    end else begin
      dec_q <= fetch_slot;
    end
  end

  assign opcode = dec_q.insn[6:0];
  assign rd = dec_q.insn[11:7];
  assign funct3 = dec_q.insn[14:12];
  assign rs1 = dec_q.insn[19:15];
  assign rs2 = dec_q.insn[24:20];
  assign funct7 = dec_q.insn[31:25];

  // one immediate per instruction, chosen by format
  always_comb begin
    case (opcode)
      rv_pkg::op_branch: begin
        imm = {{20{dec_q.insn[31]}}, dec_q.insn[7], dec_q.insn[30:25],
               dec_q.insn[11:8], 1'b0};
      end
      rv_pkg::op_lui: imm = {dec_q.insn[31:12], 12'b0};
      default: imm = {{20{dec_q.insn[31]}}, dec_q.insn[31:20]};
    endcase
  end

  always_comb begin
    op = rv_pkg::op_nop;
    case (opcode)
      rv_pkg::op_lui: op = rv_pkg::op_load_upper;
      rv_pkg::op_reg_imm: begin
        case (funct3)
          3'b000: op = rv_pkg::op_addi;
          3'b010: op = rv_pkg::op_slti;
          3'b011: op = rv_pkg::op_sltiu;
          3'b100: op = rv_pkg::op_xori;
          3'b110: op = rv_pkg::op_ori;
          3'b111: op = rv_pkg::op_andi;
          3'b001: if (funct7 == 7'd0) op = rv_pkg::op_slli;
          3'b101: begin
            if (funct7 == 7'd0) op = rv_pkg::op_srli;
            else if (funct7 == rv_pkg::funct7_alt) op = rv_pkg::op_srai;
          end
        endcase
      end
      rv_pkg::op_reg_reg: begin
        if (funct7 == 7'd0) begin
          case (funct3)
            3'b000: op = rv_pkg::op_add;
            3'b001: op = rv_pkg::op_sll;
            3'b010: op = rv_pkg::op_slt;
            3'b011: op = rv_pkg::op_sltu;
            3'b100: op = rv_pkg::op_xor;
            3'b101: op = rv_pkg::op_srl;
            3'b110: op = rv_pkg::op_or;
            3'b111: op = rv_pkg::op_and;
          endcase
        end else if (funct7 == rv_pkg::funct7_alt) begin
          if (funct3 == 3'b000) op = rv_pkg::op_sub;
          else if (funct3 == 3'b101) op = rv_pkg::op_sra;
        end
      end
      rv_pkg::op_branch: begin
        case (funct3)
          3'b000: op = rv_pkg::op_beq;
          3'b001: op = rv_pkg::op_bne;
          3'b100: op = rv_pkg::op_blt;
          3'b101: op = rv_pkg::op_bge;
          3'b110: op = rv_pkg::op_bltu;
          3'b111: op = rv_pkg::op_bgeu;
          default: op = rv_pkg::op_nop;
        endcase
      end
      rv_pkg::op_environ: if (dec_q.insn[31:7] == 25'd0) op = rv_pkg::op_ecall;
      default: op = rv_pkg::op_nop;
    endcase
  end

  // branches, ecall and nops carry rd zero so forwarding never matches them
  always_comb begin
    case (op)
      rv_pkg::op_nop, rv_pkg::op_ecall,
      rv_pkg::op_beq, rv_pkg::op_bne, rv_pkg::op_blt,
      rv_pkg::op_bge, rv_pkg::op_bltu, rv_pkg::op_bgeu: writes_rd = 1'b0;
      default: writes_rd = 1'b1;
    endcase
  end

  assign exec_slot = '{
    pc: dec_q.pc,
    insn: dec_q.insn,
    status: dec_q.status,
    op: op,
    rs1: rs1,
    rs2: rs2,
    rd: writes_rd ? rd : '0,
    imm: imm,
    shamt: dec_q.insn[24:20]
  };

endmodule

/* src/reg_file.sv */
module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data
);

  rv_pkg::word_t regs [rv_pkg::num_regs];

  // x0 is cleared here and never written afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // decode and execute already drop writes aimed at x0
  no_x0_write: assert property (@(posedge clk) disable iff (rst) we |-> rd != '0)
    else $error("write to x0 requested");

endmodule

/* src/execute_stage.sv */
module execute_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_pkg::exec_slot_t   exec_in,
  output rv_pkg::reg_idx_t     rs1,
  output rv_pkg::reg_idx_t     rs2,
  input  rv_pkg::word_t        rs1_data,
  input  rv_pkg::word_t        rs2_data,
  input  rv_pkg::retire_slot_t mem_slot,
  input  rv_pkg::retire_slot_t wb_slot,
  output rv_pkg::redirect_t    redirect,
  output rv_pkg::retire_slot_t retire_in
);

  rv_pkg::exec_slot_t ex_q;
  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_b;
  logic use_imm;
  logic [4:0] shift;
  logic lt_s;
  logic lt_u;
  rv_pkg::word_t result;
  logic branch_taken;
  logic we;

  // memory slot is younger, so it wins over writeback
  function automatic rv_pkg::word_t forward(
    input rv_pkg::reg_idx_t     idx,
    input rv_pkg::word_t        rf_data,
    input rv_pkg::retire_slot_t m,
    input rv_pkg::retire_slot_t w
  );
    rv_pkg::word_t value;
    if (idx != '0 && idx == m.rd) begin
      value = m.rd_data;
    end else if (idx != '0 && idx == w.rd) begin
      value = w.rd_data;
    end else begin
      value = rf_data;
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_q <= '{pc: '0, insn: '0, status: rv_pkg::cycle_reset, op: rv_pkg::op_nop,
                rs1: '0, rs2: '0, rd: '0, imm: '0, shamt: '0};
    end else if (redirect.taken) begin
      ex_q <= '{pc: '0, insn: '0, status: rv_pkg::cycle_taken_branch, op: rv_pkg::op_nop,
                rs1: '0, rs2: '0, rd: '0, imm: '0, shamt: '0};
    end else begin
      ex_q <= exec_in;
    end
  end

  assign rs1 = ex_q.rs1;
  assign rs2 = ex_q.rs2;
  assign op_a = forward(ex_q.rs1, rs1_data, mem_slot, wb_slot);
  assign op_b = forward(ex_q.rs2, rs2_data, mem_slot, wb_slot);

  // reg-imm ops share the reg-reg datapath with the immediate as second operand
  assign use_imm = (ex_q.insn[6:0] == rv_pkg::op_reg_imm);
  assign alu_b = use_imm ? ex_q.imm : op_b;
  assign shift = use_imm ? ex_q.shamt : op_b[4:0];
  assign lt_s = $signed(op_a) < $signed(alu_b);
  assign lt_u = op_a < alu_b;

  always_comb begin
    result = '0;
    branch_taken = 1'b0;
    case (ex_q.op)
      rv_pkg::op_load_upper: result = ex_q.imm;
      rv_pkg::op_addi, rv_pkg::op_add: result = op_a + alu_b;
      rv_pkg::op_sub: result = op_a - alu_b;
      rv_pkg::op_slti, rv_pkg::op_slt: result = rv_pkg::word_t'(lt_s);
      rv_pkg::op_sltiu, rv_pkg::op_sltu: result = rv_pkg::word_t'(lt_u);
      rv_pkg::op_xori, rv_pkg::op_xor: result = op_a ^ alu_b;
      rv_pkg::op_ori, rv_pkg::op_or: result = op_a | alu_b;
      rv_pkg::op_andi, rv_pkg::op_and: result = op_a & alu_b;
      rv_pkg::op_slli, rv_pkg::op_sll: result = op_a << shift;
      rv_pkg::op_srli, rv_pkg::op_srl: result = op_a >> shift;
      rv_pkg::op_srai, rv_pkg::op_sra: result = $signed(op_a) >>> shift;
      rv_pkg::op_beq: branch_taken = (op_a == alu_b);
      rv_pkg::op_bne: branch_taken = (op_a != alu_b);
      rv_pkg::op_blt: branch_taken = lt_s;
      rv_pkg::op_bge: branch_taken = !lt_s;
      rv_pkg::op_bltu: branch_taken = lt_u;
      rv_pkg::op_bgeu: branch_taken = !lt_u;
      default: result = '0;
    endcase
  end

  // rd is already zero for anything that does not write
  assign we = (ex_q.rd != '0);

  assign redirect = '{taken: branch_taken, target: ex_q.pc + ex_q.imm};

  assign retire_in = '{
    pc: ex_q.pc,
    insn: ex_q.insn,
    status: ex_q.status,
    rd: ex_q.rd,
    rd_data: we ? result : '0,
    we: we,
    halt: (ex_q.op == rv_pkg::op_ecall)
  };

  // flushed and reset slots must decode to something harmless
  bubble_no_redirect: assert property (@(posedge clk) disable iff (rst)
    redirect.taken |-> ex_q.status == rv_pkg::cycle_no_stall)
    else $error("bubble at pc %h raised a redirect", ex_q.pc);

endmodule

/* src/retire_stage.sv */
module retire_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::retire_slot_t  retire_in,
  output rv_pkg::retire_slot_t  mem_slot,
  output rv_pkg::retire_slot_t  wb_slot,
  output logic                  rf_we,
  output rv_pkg::reg_idx_t      rf_rd,
  output rv_pkg::word_t         rf_rd_data,
  output logic                  halt,
  output rv_pkg::word_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status,
  output logic                  trace_we,
  output rv_pkg::reg_idx_t      trace_rd,
  output rv_pkg::word_t         trace_rd_data
);

  rv_pkg::retire_slot_t mem_q;
  rv_pkg::retire_slot_t wb_q;

  // no data memory, the memory slot only adds a cycle of latency
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_q <= '{pc: '0, insn: '0, status: rv_pkg::cycle_reset, rd: '0,
                 rd_data: '0, we: 1'b0, halt: 1'b0};
      wb_q <= '{pc: '0, insn: '0, status: rv_pkg::cycle_reset, rd: '0,
                rd_data: '0, we: 1'b0, halt: 1'b0};
    end else begin
      mem_q <= retire_in;
      wb_q <= mem_q;
    end
  end

  assign mem_slot = mem_q;
  assign wb_slot = wb_q;

  assign rf_we = wb_q.we;
  assign rf_rd = wb_q.rd;
  assign rf_rd_data = wb_q.rd_data;

  // ecall stops the core as it leaves writeback
  assign halt = wb_q.halt;

  assign trace_pc = wb_q.pc;
  assign trace_insn = wb_q.insn;
  assign trace_status = wb_q.status;
  assign trace_we = wb_q.we;
  assign trace_rd = wb_q.rd;
  assign trace_rd_data = wb_q.rd_data;

endmodule

/* src/rv_pipeline.sv */
module rv_pipeline (
  input  logic                  clk,
  input  logic                  rst,
  output rv_pkg::word_t         imem_addr,
  input  rv_pkg::insn_t         imem_data,
  output logic                  halt,
  output rv_pkg::word_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status,
  output logic                  trace_we,
  output rv_pkg::reg_idx_t      trace_rd,
  output rv_pkg::word_t         trace_rd_data
);

  rv_pkg::redirect_t redirect;
  rv_pkg::fetch_slot_t fetch_slot;
  rv_pkg::exec_slot_t exec_slot;
  rv_pkg::retire_slot_t retire_in;
  rv_pkg::retire_slot_t mem_slot;
  rv_pkg::retire_slot_t wb_slot;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  logic rf_we;
  rv_pkg::reg_idx_t rf_rd;
  rv_pkg::word_t rf_rd_data;

  fetch_unit u_fetch (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .fetch_slot (fetch_slot)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .fetch_slot (fetch_slot),
    .exec_slot  (exec_slot)
  );

  // reads happen in execute, the write comes from writeback
  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .rd_data  (rf_rd_data)
  );

  execute_stage u_execute (
    .clk       (clk),
    .rst       (rst),
    .exec_in   (exec_slot),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .mem_slot  (mem_slot),
    .wb_slot   (wb_slot),
    .redirect  (redirect),
    .retire_in (retire_in)
  );

  retire_stage u_retire (
    .clk           (clk),
    .rst           (rst),
    .retire_in     (retire_in),
    .mem_slot      (mem_slot),
    .wb_slot       (wb_slot),
    .rf_we         (rf_we),
    .rf_rd         (rf_rd),
    .rf_rd_data    (rf_rd_data),
    .halt          (halt),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_we      (trace_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data)
  );

endmodule

/* dv/tb_rv_pipeline.sv */
module tb_rv_pipeline;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_tests = 5;
  localparam int setup_len = 14;
  localparam int prog_len = 56;
  localparam int timeout_cycles = num_tests * (prog_len * 4 + 20);

  // one retirement as the model predicts it
  typedef struct packed {
    rv_pkg::word_t    pc;
    rv_pkg::insn_t    insn;
    logic             we;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    data;
    logic             taken;
    logic             halt;
  } retire_exp_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  rv_pkg::word_t imem_addr;
  rv_pkg::insn_t imem_data = '0;
  logic halt;
  rv_pkg::word_t trace_pc;
  rv_pkg::insn_t trace_insn;
  rv_pkg::cycle_status_e trace_status;
  logic trace_we;
  rv_pkg::reg_idx_t trace_rd;
  rv_pkg::word_t trace_rd_data;

  rv_pkg::insn_t imem [256];
  retire_exp_t exp_q [$];
  int checks = 0;
  int errors = 0;
  int passed = 0;
  int cycle_count = 0;

  rv_pipeline uut (
    .clk           (clk),
    .rst           (rst),
    .imem_addr     (imem_addr),
    .imem_data     (imem_data),
    .halt          (halt),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_we      (trace_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data)
  );

  always #2 clk = ~clk;

  // synchronous-read instruction memory returns the word one cycle later
  always @(posedge clk) begin
    imem_data <= imem[imem_addr[9:2]];
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("timeout after %0d cycles, the core never reached halt", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  function automatic rv_pkg::insn_t r_type(logic [6:0] f7, rv_pkg::reg_idx_t rs2,
                                           rv_pkg::reg_idx_t rs1, logic [2:0] f3,
                                           rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
  endfunction

  function automatic rv_pkg::insn_t i_type(logic [11:0] imm, rv_pkg::reg_idx_t rs1,
                                           logic [2:0] f3, rv_pkg::reg_idx_t rd);
    return {imm, rs1, f3, rd, rv_pkg::op_reg_imm};
  endfunction

  function automatic rv_pkg::insn_t u_type(logic [19:0] imm, rv_pkg::reg_idx_t rd);
    return {imm, rd, rv_pkg::op_lui};
  endfunction

  function automatic rv_pkg::insn_t b_type(logic [12:0] off, rv_pkg::reg_idx_t rs2,
                                           rv_pkg::reg_idx_t rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
  endfunction

  task automatic build_program();
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    logic [2:0] f3;
    logic [4:0] shamt;
    logic [11:0] imm12;
    logic alt;
    int kind;
    int room;
    int sel;
    // unused words are addi x0, x0 with the word index as immediate
    for (int i = 0; i < 256; i++) begin
      imem[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0);
    end
    for (int r = 1; r < 8; r++) begin
      imem[2 * r - 2] = u_type(20'($urandom), 5'(r));
      imem[2 * r - 1] = i_type(12'($urandom), 5'(r), 3'b000, 5'(r));
    end
    // body works on x0..x7 only, so most operands come through forwarding
    for (int i = setup_len; i < prog_len - 1; i++) begin
      rd = 5'($urandom_range(7, 0));
      rs1 = 5'($urandom_range(7, 0));
      rs2 = 5'($urandom_range(7, 0));
      f3 = 3'($urandom);
      shamt = 5'($urandom);
      alt = (f3 == 3'b000 || f3 == 3'b101) && ($urandom_range(1, 0) == 1);
      kind = int'($urandom_range(9, 0));
      if (kind < 4) begin
        imem[i] = r_type(alt ? rv_pkg::funct7_alt : 7'd0, rs2, rs1, f3, rd);
      end else if (kind < 7) begin
        if (f3 == 3'b001) begin
          imm12 = {7'd0, shamt};
        end else if (f3 == 3'b101) begin
          imm12 = {alt ? rv_pkg::funct7_alt : 7'd0, shamt};
        end else begin
          imm12 = 12'($urandom);
        end
        imem[i] = i_type(imm12, rs1, f3, rd);
      end else if (kind < 8) begin
        imem[i] = u_type(20'($urandom), rd);
      end else begin
        // forward offsets that never pass the closing ecall
        room = prog_len - 1 - i;
        sel = int'($urandom_range(5, 0));
        f3 = (sel < 2) ? 3'(sel) : 3'(sel + 2);
        imem[i] = b_type(13'(4 * int'($urandom_range(room < 4 ? room : 4, 1))), rs2, rs1, f3);
      end
    end
    imem[prog_len - 1] = {25'd0, rv_pkg::op_environ};
  endtask

  // in-order instruction-set model that fills exp_q with the retirement stream
  task automatic predict_retirement();
    rv_pkg::word_t regs [32];
    rv_pkg::insn_t insn;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm;
    rv_pkg::word_t val;
    logic [4:0] sh;
    logic [12:0] boff;
    logic wr;
    logic take;
    logic stop;
    retire_exp_t e;
    int idx;
    exp_q.delete();
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    idx = 0;
    stop = 1'b0;
    while (!stop && idx < 256) begin
      insn = imem[idx];
      a = regs[insn[19:15]];
      b = regs[insn[24:20]];
      imm = {{20{insn[31]}}, insn[31:20]};
      sh = insn[24:20];
      boff = {insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      val = '0;
      wr = 1'b0;
      take = 1'b0;
      case (insn[6:0])
        rv_pkg::op_lui: begin
          val = {insn[31:12], 12'd0};
          wr = 1'b1;
        end
        rv_pkg::op_reg_imm, rv_pkg::op_reg_reg: begin
          wr = 1'b1;
          if (insn[6:0] == rv_pkg::op_reg_reg) begin
            imm = b;
            sh = b[4:0];
          end
          case (insn[14:12])
            3'b000: val = (insn[6:0] == rv_pkg::op_reg_reg && insn[30]) ? a - imm : a + imm;
            3'b001: val = a << sh;
            3'b010: val = {31'd0, $signed(a) < $signed(imm)};
            3'b011: val = {31'd0, a < imm};
            3'b100: val = a ^ imm;
            3'b101: begin
              if (insn[30]) begin
                val = $signed(a) >>> sh;
              end else begin
                val = a >> sh;
              end
            end
            3'b110: val = a | imm;
            default: val = a & imm;
          endcase
        end
        rv_pkg::op_branch: begin
          case (insn[14:12])
            3'b000: take = (a == b);
            3'b001: take = (a != b);
            3'b100: take = $signed(a) < $signed(b);
            3'b101: take = !($signed(a) < $signed(b));
            3'b110: take = a < b;
            default: take = !(a < b);
          endcase
        end
        rv_pkg::op_environ: stop = 1'b1;
        default: wr = 1'b0;
      endcase
      e.pc = 32'(idx * 4);
      e.insn = insn;
      e.we = wr && insn[11:7] != 5'd0;
      e.rd = e.we ? insn[11:7] : 5'd0;
      e.data = e.we ? val : '0;
      e.taken = take;
      e.halt = stop;
      exp_q.push_back(e);
      if (e.we) begin
        regs[insn[11:7]] = val;
      end
      idx = take ? idx + int'(boff[12:2]) : idx + 1;
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic run_test(input int t);
    retire_exp_t e;
    int retired;
    int bubbles;
    int cyc;
    int errs_before;
    logic seen_first;
    logic last_taken;
    logic done;
    errs_before = errors;
    @(posedge clk);
    rst <= 1'b1;
    build_program();
    predict_retirement();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    retired = 0;
    bubbles = 0;
    cyc = 0;
    seen_first = 1'b0;
    last_taken = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      // fetch starts at address 0 and steps one word per cycle
      if (!seen_first) begin
        check("imem_addr", imem_addr, 32'(4 * cyc));
      end
      if (trace_status == rv_pkg::cycle_no_stall) begin
        seen_first = 1'b1;
        if (retired >= exp_q.size()) begin
          $display("test %0d retired more instructions than the model predicts", t);
          errors++;
          done = 1'b1;
        end else begin
          e = exp_q[retired];
          check("trace_pc", trace_pc, e.pc);
          check("trace_insn", trace_insn, e.insn);
          check("trace_we", 32'(trace_we), 32'(e.we));
          check("trace_rd", 32'(trace_rd), 32'(e.rd));
          check("trace_rd_data", trace_rd_data, e.data);
          check("halt", 32'(halt), 32'(e.halt));
          // a taken branch leaves exactly three flushed slots behind it
          if (retired > 0) begin
            check("taken_branch bubbles", 32'(bubbles), last_taken ? 32'd3 : 32'd0);
          end
          retired++;
          bubbles = 0;
          last_taken = e.taken;
          if (e.halt || halt) begin
            check("retired count", 32'(retired), 32'(exp_q.size()));
            done = 1'b1;
          end
        end
      end else begin
        check("trace_we", 32'(trace_we), 32'd0);
        check("halt", 32'(halt), 32'd0);
        if (!seen_first) begin
          check("trace_status", 32'(trace_status), 32'(rv_pkg::cycle_reset));
        end else begin
          check("trace_status", 32'(trace_status), 32'(rv_pkg::cycle_taken_branch));
          bubbles++;
        end
      end
      cyc++;
    end
    if (errors == errs_before) begin
      passed++;
      $display("test %0d passed, %0d instructions retired", t, retired);
    end else begin
      $display("test %0d failed with %0d errors", t, errors - errs_before);
    end
  endtask

  initial begin
    void'($urandom(32'h26dd));
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d passed, %0d checks, %0d errors", num_tests, passed, checks,
             errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim.f */
src/rv_pkg.sv
src/fetch_unit.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/retire_stage.sv
src/rv_pipeline.sv
dv/tb_rv_pipeline.sv

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_rv_pipeline -f sim.f \
  && ./obj_dir/Vtb_rv_pipeline | tee /dev/stderr | grep -qx "Everything OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
